// ==== Bender.yml ====
package:
  name: zxHost

sources:
  # Package first, then leaf modules, then the top level
  - source/zxHostPkg.sv
  - source/waitTimer.sv
  - source/busController.sv
  - source/videoRam.sv
  - source/extMemPort.sv
  - source/ioPorts.sv
  - source/zxHost.sv
  - target: test
    files:
      - verif/extMemModel.sv
      - verif/tb_zxHost.sv

// ==== filelist.f ====
source/zxHostPkg.sv
source/waitTimer.sv
source/busController.sv
source/videoRam.sv
source/extMemPort.sv
source/ioPorts.sv
source/zxHost.sv
verif/extMemModel.sv
verif/tb_zxHost.sv

// ==== source/busController.sv ====
// Z80 bus controller
// Decodes strobes into a target region, stretches the cycle with nWait
// for the region latency and steers read data and write strobes

`timescale 1ns/10ps

module busController (
    input  logic                clkCpu,
    input  logic                rst,
    input  zxHostPkg::addr_t    addr,
    input  logic                nMreq,
    input  logic                nIorq,
    input  logic                nRd,
    input  logic                nWr,
    output logic                nWait,
    output logic                timerLoad,
    output zxHostPkg::waitCnt_t timerValue,
    input  logic                timerDone,
    output zxHostPkg::region_t  region,
    output logic                isWrite,
    output logic                active,      // High for the whole WAIT state
    output logic                commit,
    output logic                capture,
    output logic                ramWe,
    output logic                ioWrite,
    input  zxHostPkg::data_t    ramData,
    input  zxHostPkg::data_t    extData,
    input  zxHostPkg::data_t    ioData,
    output zxHostPkg::data_t    cpuDataOut
);
    import zxHostPkg::*;

    busState_t state;
    logic      strobesOn;                    // Any access presented by the CPU

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address map and latency select
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign strobesOn = (!nMreq || !nIorq) && (!nRd || !nWr);
    assign isWrite   = !nWr;

    always_comb begin
        if (!nIorq) region = REGION_IO;
        else if (addr[15]) region = REGION_SRAM;      // 8000-FFFF
        else if (addr[14]) region = REGION_RAM;       // 4000-7FFF
        else region = REGION_ROM;                      // 0000-3FFF
    end

    always_comb begin
        case (region)
            REGION_ROM:  timerValue = ROM_WAIT;
            REGION_SRAM: timerValue = SRAM_WAIT;
            default:     timerValue = INT_WAIT;       // RAM and I/O
        endcase
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Access FSM
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clkCpu) begin
        if (rst) begin
            state <= BUS_IDLE;
            nWait <= 1'b1;
        end else begin
            case (state)
                BUS_IDLE: if (strobesOn) begin
                    state <= BUS_WAIT;
                    nWait <= 1'b0;                    // Stretch from next edge
                end
                BUS_WAIT: if (timerDone) begin
                    state <= BUS_DONE;
                    nWait <= 1'b1;                    // Let the CPU go on
                end
                default: if (!strobesOn) state <= BUS_IDLE;  // Hold until release
            endcase
        end
    end

    assign timerLoad = (state == BUS_IDLE) && strobesOn;
    assign active    = (state == BUS_WAIT);

    // One-cycle pulses on the last WAIT cycle
    assign commit  = active && timerDone && isWrite;
    assign capture = active && timerDone && !nRd;
    assign ramWe   = commit && (region == REGION_RAM);
    assign ioWrite = isWrite && (region == REGION_IO);

    // Read byte stays put through DONE until the strobes drop
    always_ff @(posedge clkCpu) begin
        if (capture) begin
            case (region)
                REGION_RAM: cpuDataOut <= ramData;
                REGION_IO:  cpuDataOut <= ioData;
                default:    cpuDataOut <= extData;    // Flash or SRAM
            endcase
        end
    end

    assert property (@(posedge clkCpu) disable iff (rst)
        !nWait |-> (state == BUS_WAIT))
    else $error("nWait low outside WAIT");

    assert property (@(posedge clkCpu) disable iff (rst) !(commit && capture))
    else $error("commit and capture together");

endmodule

// ==== source/extMemPort.sv ====
// External memory port
// Drives flash and SRAM pins for the ROM and upper RAM windows and
// holds the byte read from them

`timescale 1ns/10ps

module extMemPort (
    input  logic                  clkCpu,
    input  logic                  rst,
    input  zxHostPkg::addr_t      addr,
    input  zxHostPkg::data_t      wrData,
    input  zxHostPkg::region_t    region,
    input  logic                  isWrite,
    input  logic                  active,
    input  logic                  capture,
    input  logic                  romSelect,
    output zxHostPkg::flashAddr_t flashAddr,
    input  zxHostPkg::data_t      flashData,
    output zxHostPkg::sramAddr_t  sramAddr,
    output zxHostPkg::data_t      sramDataOut,
    output logic                  sramWeN,
    input  zxHostPkg::data_t      sramDataIn,
    output zxHostPkg::data_t      extData
);
    import zxHostPkg::*;

    data_t pinData;                      // Byte on the selected chip pins
    data_t heldData;                     // Last captured external byte
    logic  extRead;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address mapping
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Two 16K ROM images sit back to back in flash, romSelect picks one
    assign flashAddr = {7'b0, romSelect, addr[13:0]};
    assign sramAddr  = {3'b0, addr[14:0]};          // 32K window at 8000

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write path
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Flash has no write pin here, so ROM writes just run their wait
    assign sramDataOut = wrData;
    assign sramWeN     = !(active && isWrite && (region == REGION_SRAM));

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read path
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign pinData = (region == REGION_ROM) ? flashData : sramDataIn;
    assign extRead = capture && ((region == REGION_ROM) || (region == REGION_SRAM));

    always_ff @(posedge clkCpu) begin
        if (rst) begin
            heldData <= '0;
        end else if (extRead) begin
            heldData <= pinData;
        end
    end

    // Pins pass straight through on the capture cycle itself
    assign extData = capture ? pinData : heldData;

    // Write strobe only ever in the 8000-FFFF address window
    assert property (@(posedge clkCpu) disable iff (rst)
        !sramWeN |-> addr[15])
    else $error("SRAM write strobe outside SRAM window");

endmodule

// ==== source/ioPorts.sv ====
// ULA and joystick I/O ports
// Border and beeper register on even ports, keyboard and tape read
// on even ports, Kempston joystick on port 1F

`timescale 1ns/10ps

module ioPorts (
    input  logic                  clkCpu,
    input  logic                  rst,
    input  zxHostPkg::addr_t      addr,
    input  zxHostPkg::data_t      wrData,
    input  logic                  commit,
    input  logic                  ioWrite,
    input  zxHostPkg::keyMatrix_t keyMatrix,
    input  logic                  earIn,
    input  logic [5:0]            kempston,  // Active low pad buttons
    output zxHostPkg::data_t      ioData,
    output logic [2:0]            border,
    output logic                  beeper
);
    import zxHostPkg::*;

    logic       ulaPort;                 // Even address decodes the ULA
    logic [4:0] keyRows;                 // AND of selected rows
    data_t      kempData;

    assign ulaPort = !addr[0];

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ULA output register
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clkCpu) begin
        if (rst) begin
            border <= 3'd0;
            beeper <= 1'b0;
        end else if (commit && ioWrite && ulaPort) begin
            border <= wrData[2:0];       // Border colour
            beeper <= wrData[4];         // Speaker
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Keyboard rows
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // A low address bit 8+r pulls in row r, pressed keys read as zero
    always_comb begin
        keyRows = 5'h1F;
        for (int r = 0; r < 8; r++) begin
            if (!addr[8+r]) begin
                keyRows = keyRows & keyMatrix[r*5 +: 5];
            end
        end
    end

    // Joystick reads 000FUDLR active high
    // Bit 1 of the pad has no Kempston function
    assign kempData = {3'b000,
                       !kempston[3],     // Fire
                       !kempston[5],     // Up
                       !kempston[4],     // Down
                       !kempston[0],     // Left
                       !kempston[2]};    // Right

    always_comb begin
        if (ulaPort) begin
            ioData = {1'b1, earIn, 1'b1, keyRows};     // Tape in bit 6
        end else if (addr[7:0] == KEMPSTON_PORT) begin
            ioData = kempData;
        end else begin
            ioData = 8'hFF;              // Unused odd ports float high
        end
    end

endmodule

// ==== source/videoRam.sv ====
// Video RAM
// 16K dual-port RAM, CPU read/write on one port and a read-only
// video fetch port on the other, both with one cycle read latency

`timescale 1ns/10ps

module videoRam (
    input  logic                 clkCpu,
    input  zxHostPkg::ramAddr_t  cpuAddr,
    input  zxHostPkg::data_t     cpuWrData,
    input  logic                 cpuWe,
    output zxHostPkg::data_t     cpuRdData,
    input  zxHostPkg::vramAddr_t vramAddr,
    output zxHostPkg::data_t     vramData
);
    import zxHostPkg::*;

    localparam int RAM_DEPTH = 16384;

    data_t mem [RAM_DEPTH];

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CPU side
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clkCpu) begin
        if (cpuWe) begin
            mem[cpuAddr] <= cpuWrData;
        end
        cpuRdData <= mem[cpuAddr];           // Old data on a write cycle
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Video side
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Screen lives in the lower 8K, 4000-5AFF on the CPU map
    always_ff @(posedge clkCpu) begin
        vramData <= mem[{1'b0, vramAddr}];
    end

endmodule

// ==== source/waitTimer.sv ====
// Wait timer
// Loadable down-counter that flags the last cycle of an access latency

`timescale 1ns/10ps

module waitTimer (
    input  logic               clkCpu,
    input  logic               rst,
    input  logic               load,
    input  zxHostPkg::waitCnt_t loadValue,
    output logic               done
);
    import zxHostPkg::*;

    waitCnt_t count;                     // Cycles left, zero when idle

    always_ff @(posedge clkCpu) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= loadValue;
        end else if (count != '0) begin
            count <= count - 3'd1;       // Runs down to zero and parks
        end
    end

    // Last cycle of the latency, N cycles after the load edge
    assign done = (count == 3'd1);

    // The Z80 bus has one access in flight, so a reload mid-count means
    // the controller lost track of the running access
    assert property (@(posedge clkCpu) disable iff (rst)
        load |-> (count == '0))
    else $error("waitTimer reloaded while counting");

endmodule

// ==== source/zxHost.sv ====
// ZX host top level
// Ties the Z80 bus controller and wait timer to the internal video
// RAM, the flash/SRAM pins and the ULA and joystick ports

`timescale 1ns/10ps

module zxHost (
    input  logic                  clkCpu,
    input  logic                  rst,
    // CPU bus
    input  zxHostPkg::addr_t      addr,
    input  zxHostPkg::data_t      cpuDataIn,
    output zxHostPkg::data_t      cpuDataOut,
    input  logic                  nMreq,
    input  logic                  nIorq,
    input  logic                  nRd,
    input  logic                  nWr,
    output logic                  nWait,
    // External memories
    input  logic                  romSelect,
    output zxHostPkg::flashAddr_t flashAddr,
    input  zxHostPkg::data_t      flashData,
    output zxHostPkg::sramAddr_t  sramAddr,
    output zxHostPkg::data_t      sramDataOut,
    output logic                  sramWeN,
    input  zxHostPkg::data_t      sramDataIn,
    // Video fetch
    input  zxHostPkg::vramAddr_t  vramAddr,
    output zxHostPkg::data_t      vramData,
    // ULA and joystick
    input  zxHostPkg::keyMatrix_t keyMatrix,
    input  logic                  earIn,
    input  logic [5:0]            kempston,
    output logic [2:0]            border,
    output logic                  beeper
);
    import zxHostPkg::*;

    logic     timerLoad, timerDone;
    waitCnt_t timerValue;
    region_t  region;
    logic     isWrite, active, commit, capture, ramWe, ioWrite;
    data_t    ramData, extData, ioData;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus control
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    busController busController_i (
        .clkCpu, .rst, .addr, .nMreq, .nIorq, .nRd, .nWr, .nWait,
        .timerLoad, .timerValue, .timerDone, .region, .isWrite, .active,
        .commit, .capture, .ramWe, .ioWrite, .ramData, .extData, .ioData,
        .cpuDataOut
    );

    waitTimer waitTimer_i (
        .clkCpu, .rst,
        .load      (timerLoad),
        .loadValue (timerValue),
        .done      (timerDone)
    );

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memories and ports
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    videoRam videoRam_i (
        .clkCpu,
        .cpuAddr   (addr[13:0]),         // 4000-7FFF folds onto 0000-3FFF
        .cpuWrData (cpuDataIn),
        .cpuWe     (ramWe),
        .cpuRdData (ramData),
        .vramAddr, .vramData
    );

    extMemPort extMemPort_i (
        .clkCpu, .rst, .addr,
        .wrData    (cpuDataIn),
        .region, .isWrite, .active, .capture, .romSelect,
        .flashAddr, .flashData, .sramAddr, .sramDataOut, .sramWeN, .sramDataIn,
        .extData
    );

    ioPorts ioPorts_i (
        .clkCpu, .rst, .addr,
        .wrData    (cpuDataIn),
        .commit, .ioWrite, .keyMatrix, .earIn, .kempston, .ioData,
        .border, .beeper
    );

endmodule

// ==== source/zxHostPkg.sv ====
// ZX host shared definitions
// Bus widths, region and state encodings, access latencies

package zxHostPkg;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus and memory widths
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [15:0] addr_t;         // Z80 address bus
    typedef logic [7:0]  data_t;         // Z80 data byte
    typedef logic [13:0] ramAddr_t;      // Internal 16K RAM
    typedef logic [12:0] vramAddr_t;     // Bitmap and attributes, lower 8K
    typedef logic [21:0] flashAddr_t;    // Flash pins
    typedef logic [17:0] sramAddr_t;     // SRAM pins
    typedef logic [39:0] keyMatrix_t;    // 8 rows x 5 keys, active low
    typedef logic [2:0]  waitCnt_t;      // Wait timer count

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Encodings
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        REGION_ROM,                      // 0000-3FFF, flash
        REGION_RAM,                      // 4000-7FFF, internal dual port
        REGION_SRAM,                     // 8000-FFFF, external SRAM
        REGION_IO                        // Any I/O cycle
    } region_t;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_WAIT,                        // nWait held low
        BUS_DONE                         // Waiting for strobes to release
    } busState_t;

    // Latency of each target in clkCpu cycles
    localparam waitCnt_t ROM_WAIT  = 3'd3;
    localparam waitCnt_t SRAM_WAIT = 3'd2;
    localparam waitCnt_t INT_WAIT  = 3'd1;   // Internal RAM and I/O

    localparam data_t KEMPSTON_PORT = 8'h1F;

endpackage

// ==== verif/extMemModel.sv ====
// External memory model
// Flash returns a fixed byte per address, SRAM is plain byte storage

`timescale 1ns/10ps

module extMemModel (
    input  logic                  clkCpu,
    input  zxHostPkg::flashAddr_t flashAddr,
    output zxHostPkg::data_t      flashData,
    input  zxHostPkg::sramAddr_t  sramAddr,
    input  zxHostPkg::data_t      sramDataOut,
    input  logic                  sramWeN,
    output zxHostPkg::data_t      sramDataIn
);
    import zxHostPkg::*;

    data_t sram [262144];                // Full 18-bit SRAM space

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Flash
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Low address byte, scrambled with A5 in the upper ROM bank
    assign flashData = flashAddr[7:0] ^ (flashAddr[14] ? 8'hA5 : 8'h00);

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SRAM
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clkCpu) begin
        if (!sramWeN) begin
            sram[sramAddr] <= sramDataOut;   // Stored while the strobe is low
        end
    end

    assign sramDataIn = sram[sramAddr];      // Asynchronous read

endmodule

// ==== verif/tb_zxHost.sv ====
// ZX host testbench
// Directed tests of reset, ROM, internal RAM, SRAM and I/O through the Z80 bus

`timescale 1ns/10ps

module tb_zxHost;
    import zxHostPkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    // Reset, ROM, RAM, SRAM and I/O tests in that order
    localparam int NUM_ACCESSES = 2 + 13 + 32 + 36 + 12;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ACCESSES * 20 + 200;

    logic       clkCpu, rst, nMreq, nIorq, nRd, nWr, nWait, romSelect, sramWeN;
    logic       earIn, beeper;
    logic [5:0] kempston;
    logic [2:0] border;
    addr_t      addr;
    data_t      cpuDataIn, cpuDataOut, flashData, sramDataOut, sramDataIn, vramData;
    flashAddr_t flashAddr;
    sramAddr_t  sramAddr;
    vramAddr_t  vramAddr;
    keyMatrix_t keyMatrix;

    integer     seed;
    data_t      expMem [65536];          // Expected bytes by CPU address
    addr_t      written [$];             // Addresses of the current test

    zxHost dut_i (
        .clkCpu, .rst, .addr, .cpuDataIn, .cpuDataOut, .nMreq, .nIorq, .nRd, .nWr,
        .nWait, .romSelect, .flashAddr, .flashData, .sramAddr, .sramDataOut,
        .sramWeN, .sramDataIn, .vramAddr, .vramData, .keyMatrix, .earIn,
        .kempston, .border, .beeper
    );

    extMemModel mem_i (
        .clkCpu, .flashAddr, .flashData, .sramAddr, .sramDataOut, .sramWeN, .sramDataIn
    );

    always #(CLK_PERIOD / 2) clkCpu = !clkCpu;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stopOnMismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("test failed");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic compareData(input data_t got, input data_t exp, input string what);
        if (got !== exp) stopOnMismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic compareBits(input logic [2:0] gotBorder, input logic gotBeeper,
                               input logic [2:0] expBorder, input logic expBeeper,
                               input string what);
        if (gotBorder !== expBorder || gotBeeper !== expBeeper) begin
            stopOnMismatch($sformatf("%s border/beeper %0d/%b expected %0d/%b", what,
                                     gotBorder, gotBeeper, expBorder, expBeeper));
        end
    endtask

    task automatic checkLevel(input logic got, input logic exp, input string what);
        if (got !== exp) stopOnMismatch($sformatf("%s is %b expected %b", what, got, exp));
    endtask

    task automatic checkLatency(input int got, input waitCnt_t exp, input string what);
        if (got !== exp) stopOnMismatch($sformatf("%s waited %0d expected %0d", what, got, exp));
    endtask

    // Latency by address map: flash, internal, SRAM
    function automatic waitCnt_t expectedWait(input addr_t a, input logic io);
        if (io) return INT_WAIT;
        if (a >= 16'h8000) return SRAM_WAIT;
        if (a >= 16'h4000) return INT_WAIT;
        return ROM_WAIT;
    endfunction

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus tasks, entered and left on a falling edge
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic runAccess(input addr_t a, input data_t wd, input logic io,
                             input logic wr, output data_t rd);
        int       cycles;
        int       lowCycles;
        logic     released;
        logic     sramWrite;
        cycles = 0;
        lowCycles = 0;
        released = 1'b0;
        sramWrite = wr && !io && (a >= 16'h8000);   // Only access that strobes sramWeN
        addr = a;
        cpuDataIn = wd;
        nMreq = io;                      // Memory or I/O cycle
        nIorq = !io;
        nRd = wr;
        nWr = !wr;
        while (!released) begin
            @(negedge clkCpu);
            cycles++;
            // Strobe low for exactly the wait period of an SRAM write
            checkLevel(sramWeN, !(sramWrite && (cycles <= expectedWait(a, io))),
                       $sformatf("sramWeN in access at %h", a));
            if (!nWait) lowCycles++;
            else if (cycles >= 2) released = 1'b1;
        end
        rd = cpuDataOut;                 // Same value the CPU takes at the next rise
        checkLatency(lowCycles, expectedWait(a, io), $sformatf("Access at %h", a));
        @(negedge clkCpu);               // Sampling edge has passed
        nMreq = 1'b1;
        nIorq = 1'b1;
        nRd = 1'b1;
        nWr = 1'b1;
        @(negedge clkCpu);               // Idle gap
    endtask

    task automatic busWrite(input addr_t a, input data_t wd, input logic io);
        data_t unused;
        runAccess(a, wd, io, 1'b1, unused);
    endtask

    task automatic busRead(input addr_t a, input logic io, output data_t rd);
        runAccess(a, 8'h00, io, 1'b0, rd);
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic testReset();
        data_t rd;
        checkLevel(nWait, 1'b1, "nWait after reset");
        compareBits(border, beeper, 3'd0, 1'b0, "After reset");
        repeat (4) begin
            @(negedge clkCpu);
            checkLevel(sramWeN, 1'b1, "sramWeN while idle");
        end
        busWrite(16'h4000, 8'h3C, 1'b0);
        busRead(16'h4000, 1'b0, rd);
        compareData(rd, 8'h3C, "First access");
    endtask

    task automatic testRom();
        addr_t romAddrs [4];
        data_t rd;
        romAddrs = '{16'h0000, 16'h0123, 16'h2A5C, 16'h3FFF};
        for (int sel = 0; sel < 2; sel++) begin
            romSelect = sel[0];
            foreach (romAddrs[i]) begin
                busRead(romAddrs[i], 1'b0, rd);
                compareData(rd, romAddrs[i][7:0] ^ (sel[0] ? 8'hA5 : 8'h00),
                            $sformatf("ROM bank %0d at %h", sel, romAddrs[i]));
            end
        end
        busWrite(16'h0123, 8'h5A, 1'b0);  // Lands nowhere
        foreach (romAddrs[i]) begin
            busRead(romAddrs[i], 1'b0, rd);
            compareData(rd, romAddrs[i][7:0] ^ 8'hA5,
                        $sformatf("ROM after write %h", romAddrs[i]));
        end
    endtask

    // Even entries stay in the screen area below 6000
    task automatic testRam();
        logic [31:0] rnd;
        addr_t       a;
        data_t       rd;
        written.delete();
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            a = (i % 2 == 0) ? {3'b010, rnd[12:0]} : {2'b01, rnd[13:0]};
            busWrite(a, rnd[23:16], 1'b0);
            expMem[a] = rnd[23:16];
            written.push_back(a);
        end
        foreach (written[i]) begin
            busRead(written[i], 1'b0, rd);
            compareData(rd, expMem[written[i]], $sformatf("RAM at %h", written[i]));
        end
        foreach (written[i]) begin
            if (written[i] < 16'h6000) begin
                vramAddr = written[i][12:0];
                @(negedge clkCpu);       // One cycle of read latency
                compareData(vramData, expMem[written[i]], $sformatf("Video at %h", written[i]));
            end
        end
    endtask

    task automatic testSram();
        logic [31:0] rnd;
        addr_t       a;
        data_t       rd;
        written.delete();
        written.push_back(16'h8000);     // Window edges
        written.push_back(16'hFFFF);
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            written.push_back({1'b1, rnd[14:0]});
        end
        foreach (written[i]) begin
            rnd = $random(seed);
            busWrite(written[i], rnd[7:0], 1'b0);
            expMem[written[i]] = rnd[7:0];
        end
        foreach (written[i]) begin
            busRead(written[i], 1'b0, rd);
            compareData(rd, expMem[written[i]], $sformatf("SRAM at %h", written[i]));
        end
    endtask

    task automatic testIo();
        addr_t keyPorts [5];
        logic  earLevels [5];
        data_t keyExp [5];
        data_t rd;
        busWrite(16'h00FE, 8'h15, 1'b1);
        compareBits(border, beeper, 3'd5, 1'b1, "ULA write 15");
        busWrite(16'h12FE, 8'h07, 1'b1);
        compareBits(border, beeper, 3'd7, 1'b0, "ULA write 07");
        busWrite(16'h001F, 8'h13, 1'b1); // Odd port leaves the ULA alone
        compareBits(border, beeper, 3'd7, 1'b0, "Odd port write");
        busWrite(16'hABFE, 8'hEA, 1'b1);
        compareBits(border, beeper, 3'd2, 1'b0, "ULA write EA");
        // Rows 7..0 as 0A 15 1F 0F 17 1B 1D 1E
        keyMatrix = {5'h0A, 5'h15, 5'h1F, 5'h0F, 5'h17, 5'h1B, 5'h1D, 5'h1E};
        keyPorts = '{16'hFEFE, 16'h7FFE, 16'h00FE, 16'hFFFE, 16'hFCFE};
        earLevels = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
        keyExp = '{8'hFE, 8'hAA, 8'hE0, 8'hFF, 8'hBC};
        foreach (keyPorts[i]) begin
            earIn = earLevels[i];
            busRead(keyPorts[i], 1'b1, rd);
            compareData(rd, keyExp[i], $sformatf("Keyboard at %h", keyPorts[i]));
        end
        kempston = 6'b010110;            // Fire, up and left pressed
        busRead(16'h001F, 1'b1, rd);
        compareData(rd, 8'h1A, "Kempston fire/up/left");
        kempston = 6'b101011;            // Down and right pressed
        busRead(16'h771F, 1'b1, rd);
        compareData(rd, 8'h05, "Kempston down/right");
        busRead(16'h003B, 1'b1, rd);
        compareData(rd, 8'hFF, "Unused odd port");
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence and watchdog
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        seed = 32'h540b;
        clkCpu = 1'b0;
        rst = 1'b1;
        addr = '0;
        cpuDataIn = '0;
        nMreq = 1'b1;
        nIorq = 1'b1;
        nRd = 1'b1;
        nWr = 1'b1;
        romSelect = 1'b0;
        vramAddr = '0;
        keyMatrix = '1;                  // No key pressed
        earIn = 1'b0;
        kempston = 6'h3F;                // Pad released
        repeat (RESET_CYCLES) @(negedge clkCpu);
        rst = 1'b0;
        testReset();
        testRom();
        testRam();
        testSram();
        testIo();
        $display("test passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, a bus access never completed", WATCHDOG_CYCLES);
        $display("test failed");
        $fatal(1, "Watchdog expired");
    end

endmodule
